// File: src.f
+incdir+common
common/retire_pkg.sv
hdl/packet_fifo.sv
retire/commit_select.sv
retire/exception_tracker.sv
retire/retire_ctrl.sv
retire/retire_unit.sv
verification/retire_unit_checker.sv
verification/retire_unit_tb.sv

// File: verification/retire_unit_tb.sv
// Retire stage testbench

`timescale 1ns/100ps
`default_nettype none

module retire_unit_tb import retire_pkg::*; ;

    // One scenario on a single packet pushed into an empty buffer
    typedef struct packed {
        logic  d0;
        logic  d1;
        logic  late1;
        logic  dec1_v;
        code_t dec1_code;
        logic  alu_v;
        logic  alu_slot;
        code_t alu_code;
        logic  lsu_v;
        logic  lsu_slot;
        code_t lsu_code;
        logic  exp_c0;
        logic  exp_c1;
        logic  exp_trap;
    } row_t;

    localparam int NUM_ROWS = 7;
    localparam int TIMEOUT = 40;

    logic cpu_clock_i = 1'b0;
    logic rst_n_i;
    logic push_i;
    retire_packet_t packet_i;
    logic done0_i;
    logic done1_i;
    excp_report_t alu_report_i;
    excp_report_t lsu_report_i;
    logic [31:0] lsu_addr_i;
    logic mem_block_i;
    logic icache_idle_i;
    pc_t trap_base_i;
    logic busy_o;
    logic [4:0] alloc_tag_o;
    rob_tag_t oldest_tag_o;
    logic commit0_o;
    logic commit1_o;
    logic store0_o;
    logic store1_o;
    free_req_t free0_o;
    free_req_t free1_o;
    logic take_exception_o;
    trap_info_t trap_o;
    logic flush_o;
    pc_t flush_addr_o;

    row_t table_q [NUM_ROWS];
    logic [31:0] rng_state = 32'hef6e_8233;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    retire_unit dut0 (.*);

    always #2 cpu_clock_i = ~cpu_clock_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rng_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic slot_info_t random_slot();
        slot_info_t s;
        logic [31:0] r;
        r = rng_next();
        s = r[$bits(slot_info_t)-1:0];
        s.excp_valid = 1'b0;
        return s;
    endfunction

    function automatic retire_packet_t random_packet();
        retire_packet_t p;
        p.pc = pc_t'(rng_next());
        p.slot0 = random_slot();
        p.slot1 = random_slot();
        p.slot1_valid = 1'b1;
        return p;
    endfunction

    // Drive point sits just after the rising edge
    task automatic next_cycle();
        @(posedge cpu_clock_i);
        #0.5;
    endtask

    task automatic abort(input string msg);
        $display("Timeout while waiting for %s at %0t", msg, $time);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input string what, input rob_tag_t got, input rob_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_free(input string what, input free_req_t got, input free_req_t exp);
        checks++;
        if (got.en !== exp.en || (exp.en && got.preg !== exp.preg)) begin
            errors++;
            $display("FAILED %0t: %s is %b/%0d, expected %b/%0d", $time, what,
                     got.en, got.preg, exp.en, exp.preg);
        end
    endtask

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_trap(input trap_info_t got, input trap_info_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: trap epc %h cause %0d tval %h, expected %h %0d %h", $time,
                     got.epc, got.cause, got.tval, exp.epc, exp.cause, exp.tval);
        end
    endtask

    function automatic free_req_t old_free(input logic commit, input slot_info_t s);
        free_req_t f;
        f.en = commit && s.allocated && (s.old_preg != '0);
        f.preg = s.old_preg;
        return f;
    endfunction

    task automatic run_row(input int idx);
        row_t r;
        retire_packet_t pkt;
        logic [4:0] tag;
        logic [31:0] addr;
        logic lsu_older;
        logic fslot;
        trap_info_t et;
        free_req_t ef;
        int n;
        int err0;
        r = table_q[idx];
        err0 = errors;
        pkt = random_packet();
        pkt.slot1.excp_valid = r.dec1_v;
        pkt.slot1.excp_code = r.dec1_code;
        tag = alloc_tag_o;
        next_cycle();
        push_i = 1'b1;
        packet_i = pkt;
        next_cycle();
        push_i = 1'b0;
        addr = rng_next();
        lsu_addr_i = addr;
        alu_report_i = {r.alu_v, tag, r.alu_slot, r.alu_code};
        lsu_report_i = {r.lsu_v, tag, r.lsu_slot, r.lsu_code};
        next_cycle();
        alu_report_i = '0;
        lsu_report_i = '0;
        done0_i = r.d0;
        done1_i = r.d1;
        #1;
        check_tag("oldest tag", oldest_tag_o, {tag[3:0], 1'b0});
        check_bit("commit0", commit0_o, r.exp_c0);
        check_bit("commit1", commit1_o, r.exp_c1);
        check_bit("store0", store0_o, r.exp_c0 && pkt.slot0.is_store);
        check_bit("store1", store1_o, r.exp_c1 && pkt.slot1.is_store);
        check_free("free0", free0_o, old_free(r.exp_c0, pkt.slot0));
        check_free("free1", free1_o, old_free(r.exp_c1, pkt.slot1));
        if (r.late1) begin
            next_cycle();
            done1_i = 1'b1;
            #1;
            check_tag("late oldest tag", oldest_tag_o, {tag[3:0], 1'b1});
            check_bit("late commit0", commit0_o, 1'b0);
            check_bit("late commit1", commit1_o, 1'b1);
            check_free("late free1", free1_o, old_free(1'b1, pkt.slot1));
        end
        if (r.exp_trap) begin
            lsu_older = r.lsu_v && (!r.alu_v || r.lsu_slot < r.alu_slot);
            if (r.dec1_v) begin
                fslot = 1'b1;
                et.cause = r.dec1_code;
                et.tval = (r.dec1_code < 2) ? {pkt.pc + pc_t'(1), 2'b00} : '0;
            end else begin
                fslot = lsu_older ? r.lsu_slot : r.alu_slot;
                et.cause = lsu_older ? r.lsu_code : r.alu_code;
                et.tval = lsu_older ? addr : '0;
            end
            et.epc = pkt.pc + pc_t'(fslot);
            for (n = 0; !take_exception_o; n++) begin
                if (n == TIMEOUT) abort("take_exception_o");
                next_cycle();
                #1;
            end
            check_trap(trap_o, et);
            for (n = 0; !flush_o; n++) begin
                if (n == TIMEOUT) abort("flush_o");
                next_cycle();
                #1;
            end
            check_pc("flush_addr", flush_addr_o, trap_base_i);
            // Slot 0 already retired when slot 1 was the faulting one
            ef.en = pkt.slot0.allocated && !fslot;
            ef.preg = pkt.slot0.new_preg;
            check_free("recover free0", free0_o, ef);
            ef.en = pkt.slot1.allocated;
            ef.preg = pkt.slot1.new_preg;
            check_free("recover free1", free1_o, ef);
            for (n = 0; flush_o; n++) begin
                if (n == TIMEOUT) abort("end of flush");
                next_cycle();
                #1;
            end
            check_bit("flush length 16", n == 16, 1'b1);
        end
        next_cycle();
        done0_i = 1'b0;
        done1_i = 1'b0;
        tests++;
        $display("test %0d %s", idx, (errors == err0) ? "passed" : "failed");
    endtask

    task automatic fill_buffer();
        logic [4:0] tag;
        int n;
        int pops;
        int err0;
        err0 = errors;
        for (n = 0; n < 16; n++) begin
            next_cycle();
            push_i = 1'b1;
            packet_i = random_packet();
        end
        next_cycle();
        push_i = 1'b0;
        #1;
        check_bit("busy when full", busy_o, 1'b1);
        tag = alloc_tag_o;
        next_cycle();
        push_i = 1'b1;
        packet_i = random_packet();
        next_cycle();
        push_i = 1'b0;
        #1;
        check_bit("alloc tag held", alloc_tag_o == tag, 1'b1);
        next_cycle();
        done0_i = 1'b1;
        done1_i = 1'b1;
        #1;
        pops = 0;
        for (n = 0; pops < 16; n++) begin
            if (n == TIMEOUT) abort("buffer drain");
            if (commit1_o) pops++;
            next_cycle();
            #1;
        end
        check_bit("busy after drain", busy_o, 1'b0);
        tests++;
        $display("test fill %s", (errors == err0) ? "passed" : "failed");
    endtask

    initial begin
        // d0 d1 late dec code alu slot code lsu slot code c0 c1 trap
        table_q[0] = {1'b1, 1'b1, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0,
                      1'b1, 1'b1, 1'b0};
        table_q[1] = {1'b1, 1'b0, 1'b1, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0,
                      1'b1, 1'b0, 1'b0};
        table_q[2] = {1'b1, 1'b1, 1'b0, 1'b1, 4'd1, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0,
                      1'b1, 1'b0, 1'b1};
        table_q[3] = {1'b1, 1'b1, 1'b0, 1'b1, 4'd5, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0,
                      1'b1, 1'b0, 1'b1};
        table_q[4] = {1'b1, 1'b1, 1'b0, 1'b0, 4'd0, 1'b1, 1'b1, 4'd3, 1'b1, 1'b0, 4'd6,
                      1'b0, 1'b0, 1'b1};
        table_q[5] = {1'b1, 1'b1, 1'b0, 1'b0, 4'd0, 1'b1, 1'b0, 4'd2, 1'b1, 1'b1, 4'd7,
                      1'b0, 1'b0, 1'b1};
        table_q[6] = table_q[0];
        rst_n_i = 1'b0;
        push_i = 1'b0;
        packet_i = '0;
        done0_i = 1'b0;
        done1_i = 1'b0;
        alu_report_i = '0;
        lsu_report_i = '0;
        lsu_addr_i = '0;
        mem_block_i = 1'b0;
        icache_idle_i = 1'b1;
        trap_base_i = 30'h0100_0040;
        repeat (5) @(posedge cpu_clock_i);
        #0.5;
        rst_n_i = 1'b1;
        #1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        fill_buffer();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/retire_unit_checker.sv
// Retire stage assertions

`timescale 1ns/100ps
`default_nettype none

module retire_unit_checker (
    input wire logic cpu_clock_i,
    input wire logic rst_n_i,
    input wire logic take_exception_i,
    input wire logic flush_i,
    input wire logic commit0_i,
    input wire logic commit1_i,
    input wire logic busy_i
);

    // A trap is never taken while recovery is running
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        !(take_exception_i && flush_i))
        else $error("take_exception high during flush");

    // Recovery window is exactly 16 cycles long
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        $rose(flush_i) |-> flush_i [*16] ##1 !flush_i)
        else $error("flush length is not 16 cycles");

    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        flush_i |-> !commit0_i && !commit1_i)
        else $error("commit during flush");

    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        flush_i |-> busy_i)
        else $error("busy low during flush");

endmodule

bind retire_unit retire_unit_checker u_checker (
    .cpu_clock_i      (cpu_clock_i),
    .rst_n_i          (rst_n_i),
    .take_exception_i (take_exception_o),
    .flush_i          (flush_o),
    .commit0_i        (commit0_o),
    .commit1_i        (commit1_o),
    .busy_i           (busy_o)
);

`default_nettype wire

// File: retire/retire_unit.sv
// Retire stage top level

`timescale 1ns/100ps
`default_nettype none

`include "retire_defines.svh"

module retire_unit import retire_pkg::*; (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    input  wire logic           push_i,
    input  wire retire_packet_t packet_i,
    input  wire logic           done0_i,
    input  wire logic           done1_i,
    input  wire excp_report_t   alu_report_i,
    input  wire excp_report_t   lsu_report_i,
    input  wire logic [31:0]    lsu_addr_i,
    input  wire logic           mem_block_i,
    input  wire logic           icache_idle_i,
    input  wire pc_t            trap_base_i,
    output logic                busy_o,
    output logic [`RT_FIFO_IDX_W:0] alloc_tag_o,
    output rob_tag_t            oldest_tag_o,
    output logic                commit0_o,
    output logic                commit1_o,
    output logic                store0_o,
    output logic                store1_o,
    output free_req_t           free0_o,
    output free_req_t           free1_o,
    output logic                take_exception_o,
    output trap_info_t          trap_o,
    output logic                flush_o,
    output pc_t                 flush_addr_o
);

    retire_packet_t head;
    logic fifo_empty;
    logic fifo_full;
    logic fifo_pop;
    logic [`RT_FIFO_IDX_W:0] rd_ptr;
    logic [`RT_FIFO_IDX_W:0] wr_ptr;
    logic retire_en;
    logic commit_pop;
    logic partial;
    free_req_t sel_free0;
    free_req_t sel_free1;
    logic dec_fault;
    code_t cur_code;
    pc_t cur_pc;
    logic [1:0] slot_hit;
    code_t excp_code;
    logic [31:0] excp_addr;

    assign alloc_tag_o  = wr_ptr;
    assign oldest_tag_o = {rd_ptr[`RT_FIFO_IDX_W-1:0], partial};

    // Pushes arriving during recovery are dropped along with the squashed ones
    packet_fifo u_fifo (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push_i && !busy_o),
        .data_i      (packet_i),
        .pop_i       (fifo_pop),
        .head_o      (head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full),
        .rd_ptr_o    (rd_ptr),
        .wr_ptr_o    (wr_ptr)
    );

    commit_select u_commit (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .head_i       (head),
        .empty_i      (fifo_empty),
        .retire_en_i  (retire_en),
        .done0_i      (done0_i),
        .done1_i      (done1_i),
        .slot_hit_i   (slot_hit),
        .commit0_o    (commit0_o),
        .commit1_o    (commit1_o),
        .store0_o     (store0_o),
        .store1_o     (store1_o),
        .commit_pop_o (commit_pop),
        .partial_o    (partial),
        .free0_o      (sel_free0),
        .free1_o      (sel_free1),
        .dec_fault_o  (dec_fault),
        .cur_code_o   (cur_code),
        .cur_pc_o     (cur_pc)
    );

    exception_tracker u_tracker (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .alu_report_i (alu_report_i),
        .lsu_report_i (lsu_report_i),
        .lsu_addr_i   (lsu_addr_i),
        .head_ptr_i   (rd_ptr),
        .flush_i      (flush_o),
        .slot_hit_o   (slot_hit),
        .excp_code_o  (excp_code),
        .excp_addr_o  (excp_addr)
    );

    retire_ctrl u_ctrl (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .empty_i          (fifo_empty),
        .full_i           (fifo_full),
        .mem_block_i      (mem_block_i),
        .icache_idle_i    (icache_idle_i),
        .trap_base_i      (trap_base_i),
        .head_i           (head),
        .commit_pop_i     (commit_pop),
        .partial_i        (partial),
        .free0_i          (sel_free0),
        .free1_i          (sel_free1),
        .dec_fault_i      (dec_fault),
        .cur_code_i       (cur_code),
        .cur_pc_i         (cur_pc),
        .slot_hit_i       (slot_hit),
        .excp_code_i      (excp_code),
        .excp_addr_i      (excp_addr),
        .retire_en_o      (retire_en),
        .pop_o            (fifo_pop),
        .flush_o          (flush_o),
        .busy_o           (busy_o),
        .take_exception_o (take_exception_o),
        .trap_o           (trap_o),
        .flush_addr_o     (flush_addr_o),
        .free0_o          (free0_o),
        .free1_o          (free1_o)
    );

endmodule

`default_nettype wire

// File: retire/retire_ctrl.sv
// Retire controller FSM

`timescale 1ns/100ps
`default_nettype none

`include "retire_defines.svh"

module retire_ctrl import retire_pkg::*; (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    input  wire logic           empty_i,
    input  wire logic           full_i,
    input  wire logic           mem_block_i,
    input  wire logic           icache_idle_i,
    input  wire pc_t            trap_base_i,
    input  wire retire_packet_t head_i,
    input  wire logic           commit_pop_i,
    input  wire logic           partial_i,
    input  wire free_req_t      free0_i,
    input  wire free_req_t      free1_i,
    input  wire logic           dec_fault_i,
    input  wire code_t          cur_code_i,
    input  wire pc_t            cur_pc_i,
    input  wire logic [1:0]     slot_hit_i,
    input  wire code_t          excp_code_i,
    input  wire logic [31:0]    excp_addr_i,
    output logic                retire_en_o,
    output logic                pop_o,
    output logic                flush_o,
    output logic                busy_o,
    output logic                take_exception_o,
    output trap_info_t          trap_o,
    output pc_t                 flush_addr_o,
    output free_req_t           free0_o,
    output free_req_t           free1_o
);

    localparam int CNT_W = $clog2(`RT_RECOVER_CYCLES);

    retire_state_e state;
    logic [CNT_W-1:0] rec_cnt;
    logic rec_last;
    logic backend_fault;
    logic trap_partial;
    logic recovering;

    assign recovering = (state == RT_RECOVER);
    assign rec_last   = (rec_cnt == CNT_W'(`RT_RECOVER_CYCLES - 1));

    assign backend_fault = partial_i ? slot_hit_i[1] : slot_hit_i[0];

    assign take_exception_o = (state == RT_NORMAL) && !empty_i && !mem_block_i
                           && (dec_fault_i || backend_fault);

    // Decoded fault has priority over the backend record
    always_comb begin
        trap_o.epc = cur_pc_i;
        if (dec_fault_i) begin
            trap_o.cause = cur_code_i;
            // Fetch misaligned and fetch fault report the byte pc
            trap_o.tval  = (cur_code_i[3:1] == '0) ? {cur_pc_i, 2'b00} : '0;
        end else begin
            trap_o.cause = excp_code_i;
            trap_o.tval  = excp_addr_i;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= RT_NORMAL;
        end else begin
            case (state)
                RT_NORMAL:  if (take_exception_o) state <= RT_AWAIT;
                RT_AWAIT:   if (icache_idle_i) state <= RT_RECOVER;
                RT_RECOVER: if (rec_last) state <= RT_NORMAL;
                default:    state <= RT_NORMAL;
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec_cnt      <= '0;
            trap_partial <= 1'b0;
        end else begin
            rec_cnt <= recovering ? rec_cnt + 1'b1 : '0;
            // Slot 0 of the faulting packet may already be retired
            if (take_exception_o) begin
                trap_partial <= partial_i;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (take_exception_o) begin
            flush_addr_o <= trap_base_i;
        end
    end

    // Recovery returns the new registers of every squashed slot
    always_comb begin
        if (recovering) begin
            free0_o.en   = head_i.slot0.allocated && !empty_i
                        && !(trap_partial && (rec_cnt == '0));
            free0_o.preg = head_i.slot0.new_preg;
            free1_o.en   = head_i.slot1.allocated && head_i.slot1_valid && !empty_i;
            free1_o.preg = head_i.slot1.new_preg;
        end else begin
            free0_o = free0_i;
            free1_o = free1_i;
        end
    end

    assign retire_en_o = (state == RT_NORMAL);
    assign flush_o     = recovering;
    assign pop_o       = recovering ? !empty_i : commit_pop_i;
    assign busy_o      = full_i || (state != RT_NORMAL);

endmodule

`default_nettype wire

// File: retire/exception_tracker.sv
// Oldest backend exception record

`timescale 1ns/100ps
`default_nettype none

`include "retire_defines.svh"

module exception_tracker import retire_pkg::*; (
    input  wire logic                   cpu_clock_i,
    input  wire logic                   rst_n_i,
    input  wire excp_report_t           alu_report_i,
    input  wire excp_report_t           lsu_report_i,
    input  wire logic [31:0]            lsu_addr_i,
    input  wire logic [`RT_FIFO_IDX_W:0] head_ptr_i,
    input  wire logic                   flush_i,
    output logic [1:0]                  slot_hit_o,
    output code_t                       excp_code_o,
    output logic [31:0]                 excp_addr_o
);

    localparam int MSB = $bits(age_tag_t) - 1;

    logic     rec_valid;
    age_tag_t rec_tag;
    logic     lsu_wins;
    age_tag_t win_tag;
    logic     take_new;

    // True when a was allocated before b
    function automatic logic is_older(age_tag_t a, age_tag_t b);
        if (a[MSB] == b[MSB]) begin
            return a[MSB-1:0] < b[MSB-1:0];
        end
        return a[MSB-1:0] > b[MSB-1:0];
    endfunction

    assign lsu_wins = lsu_report_i.valid
                   && (!alu_report_i.valid || is_older(lsu_report_i.tag, alu_report_i.tag));
    assign win_tag  = lsu_wins ? lsu_report_i.tag : alu_report_i.tag;

    assign take_new = (alu_report_i.valid || lsu_report_i.valid) && !flush_i
                   && (!rec_valid || is_older(win_tag, rec_tag));

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec_valid <= 1'b0;
        end else if (flush_i) begin
            rec_valid <= 1'b0;
        end else if (take_new) begin
            rec_valid <= 1'b1;
        end
    end

    // ALU faults carry no address
    always_ff @(posedge cpu_clock_i) begin
        if (take_new) begin
            rec_tag     <= win_tag;
            excp_code_o <= lsu_wins ? lsu_report_i.code : alu_report_i.code;
            excp_addr_o <= lsu_wins ? lsu_addr_i : '0;
        end
    end

    assign slot_hit_o[0] = rec_valid && (rec_tag == {head_ptr_i, 1'b0});
    assign slot_hit_o[1] = rec_valid && (rec_tag == {head_ptr_i, 1'b1});

endmodule

`default_nettype wire

// File: retire/commit_select.sv
// Commit selection for the head packet

`timescale 1ns/100ps
`default_nettype none

module commit_select import retire_pkg::*; (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    input  wire retire_packet_t head_i,
    input  wire logic           empty_i,
    input  wire logic           retire_en_i,
    input  wire logic           done0_i,
    input  wire logic           done1_i,
    input  wire logic [1:0]     slot_hit_i,
    output logic                commit0_o,
    output logic                commit1_o,
    output logic                store0_o,
    output logic                store1_o,
    output logic                commit_pop_o,
    output logic                partial_o,
    output free_req_t           free0_o,
    output free_req_t           free1_o,
    output logic                dec_fault_o,
    output code_t               cur_code_o,
    output pc_t                 cur_pc_o
);

    slot_info_t s0;
    slot_info_t s1;
    logic fault0;
    logic fault1;

    assign s0 = head_i.slot0;
    assign s1 = head_i.slot1;

    // Either a decode-time fault or a recorded backend fault blocks the slot
    assign fault0 = s0.excp_valid | slot_hit_i[0];
    assign fault1 = s1.excp_valid | slot_hit_i[1];

    assign commit0_o = retire_en_i && !empty_i && !partial_o && done0_i && !fault0;
    assign commit1_o = retire_en_i && !empty_i && head_i.slot1_valid && done1_i && !fault1
                    && (commit0_o || partial_o);

    assign store0_o = commit0_o && s0.is_store;
    assign store1_o = commit1_o && s1.is_store;

    // Packet leaves once its last valid slot has committed
    assign commit_pop_o = (partial_o && commit1_o)
                       || (commit0_o && (!head_i.slot1_valid || commit1_o));

    always_comb begin
        free0_o.en   = commit0_o && s0.allocated && (s0.old_preg != '0);
        free0_o.preg = s0.old_preg;
        free1_o.en   = commit1_o && s1.allocated && (s1.old_preg != '0);
        free1_o.preg = s1.old_preg;
    end

    // Set while slot 0 has retired but slot 1 still waits
    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            partial_o <= 1'b0;
        end else if (!retire_en_i) begin
            partial_o <= 1'b0;
        end else if (partial_o) begin
            partial_o <= !commit1_o;
        end else begin
            partial_o <= commit0_o && !commit1_o && head_i.slot1_valid;
        end
    end

    // Oldest uncommitted slot of the head packet
    assign dec_fault_o = partial_o ? s1.excp_valid : s0.excp_valid;
    assign cur_code_o  = partial_o ? s1.excp_code : s0.excp_code;
    assign cur_pc_o    = head_i.pc + pc_t'(partial_o);

endmodule

`default_nettype wire

// File: hdl/packet_fifo.sv
// Retire packet buffer

`timescale 1ns/100ps
`default_nettype none

`include "retire_defines.svh"

module packet_fifo import retire_pkg::*; (
    input  wire logic                   cpu_clock_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   push_i,
    input  wire retire_packet_t         data_i,
    input  wire logic                   pop_i,
    output retire_packet_t              head_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic [`RT_FIFO_IDX_W:0]     rd_ptr_o,
    output logic [`RT_FIFO_IDX_W:0]     wr_ptr_o
);

    localparam int IDX_W = `RT_FIFO_IDX_W;
    localparam int DEPTH = 1 << IDX_W;

    retire_packet_t mem [DEPTH];
    logic do_push;
    logic do_pop;

    // Same index with different wrap bits means the writer lapped the reader
    assign full_o  = (rd_ptr_o[IDX_W-1:0] == wr_ptr_o[IDX_W-1:0])
                  && (rd_ptr_o[IDX_W] != wr_ptr_o[IDX_W]);
    assign empty_o = (rd_ptr_o == wr_ptr_o);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge cpu_clock_i) begin
        if (do_push) begin
            mem[wr_ptr_o[IDX_W-1:0]] <= data_i;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_o <= '0;
            wr_ptr_o <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_o <= wr_ptr_o + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_o <= rd_ptr_o + 1'b1;
            end
        end
    end

    assign head_o = mem[rd_ptr_o[IDX_W-1:0]];

endmodule

`default_nettype wire

// File: common/retire_pkg.sv
// Retire stage types

`default_nettype none

`include "retire_defines.svh"

package retire_pkg;

    typedef logic [`RT_PREG_W-1:0] preg_t;
    typedef logic [`RT_AREG_W-1:0] areg_t;
    typedef logic [`RT_PC_W-1:0]   pc_t;
    typedef logic [`RT_CODE_W-1:0] code_t;

    // Buffer index followed by the slot bit
    typedef logic [`RT_FIFO_IDX_W:0] rob_tag_t;

    // Tag with the wrap bit in front, for age compares
    typedef logic [`RT_FIFO_IDX_W+1:0] age_tag_t;

    typedef struct packed {
        logic  allocated;
        areg_t arch_reg;
        preg_t old_preg;
        preg_t new_preg;
        logic  excp_valid;
        code_t excp_code;
        logic  is_store;
    } slot_info_t;

    // Slot 1 sits at pc + 1
    typedef struct packed {
        pc_t        pc;
        slot_info_t slot0;
        slot_info_t slot1;
        logic       slot1_valid;
    } retire_packet_t;

    typedef struct packed {
        logic     valid;
        age_tag_t tag;
        code_t    code;
    } excp_report_t;

    typedef struct packed {
        logic  en;
        preg_t preg;
    } free_req_t;

    typedef struct packed {
        pc_t         epc;
        code_t       cause;
        logic [31:0] tval;
    } trap_info_t;

    typedef enum logic [1:0] {
        RT_NORMAL,
        RT_AWAIT,
        RT_RECOVER
    } retire_state_e;

endpackage

`default_nettype wire

// File: common/retire_defines.svh
// Retire stage parameters

`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

// Packet buffer holds 2**RT_FIFO_IDX_W packets
`define RT_FIFO_IDX_W 4

// Cycles spent in recovery after a trap
`define RT_RECOVER_CYCLES 16

// Register file widths
`define RT_PREG_W 6
`define RT_AREG_W 5

// Word program counter
`define RT_PC_W 30

// Exception cause
`define RT_CODE_W 4

`endif
